// File: common/sram_pkg.sv
// ==================================================
// sram package
// bus widths, response codes, channel states, address views
// ==================================================
package sram_pkg;

    // ==================================================
    // widths
    // ==================================================
    parameter int addr_w  = 32;
    parameter int data_w  = 32;
    parameter int strb_w  = data_w / 8;
    // 256 words, 1 KiB
    parameter int index_w = 8;
    parameter int off_w   = 2;
    parameter int tag_w   = addr_w - index_w - off_w;

    // captured address after reset, same as the core's boot fetch address
    parameter logic [addr_w-1:0] addr_rst = '0;

    // axi-lite response codes
    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_slverr = 2'b10
    } resp_t;

    // shared by both channels
    // read side never enters st_busy
    typedef enum logic [1:0] {
        st_idle   = 2'b00,
        st_busy   = 2'b01,
        st_access = 2'b10,
        st_done   = 2'b11
    } chan_state_t;

    // one address word, two views
    // nonzero tag -> outside the bank
    typedef union packed {
        logic [addr_w-1:0] raw;
        struct packed {
            logic [tag_w-1:0]   tag;
            logic [index_w-1:0] index;
            logic [off_w-1:0]   offset;
        } fields;
    } sram_addr_u;

endpackage

// File: common/sram_port_if.sv
// ==================================================
// sram port bundle
// one read port and one byte-strobed write port
// ==================================================
interface sram_port_if;
    import sram_pkg::*;

    // read port, rd_en is a one-cycle pulse
    logic               rd_en;
    logic [index_w-1:0] rd_index;
    logic [data_w-1:0]  rd_data;

    // write port, wr_en is a one-cycle pulse
    logic               wr_en;
    logic [index_w-1:0] wr_index;
    logic [data_w-1:0]  wr_data;
    logic [strb_w-1:0]  wr_strb;

    // request side
    modport req (
        output rd_en, rd_index, wr_en, wr_index, wr_data, wr_strb,
        input  rd_data
    );

    // memory side
    modport bank (
        input  rd_en, rd_index, wr_en, wr_index, wr_data, wr_strb,
        output rd_data
    );

endinterface

// File: rtl/axi_lite_sram/axi_chan_fsm.sv
// ==================================================
// axi-lite channel control
// read and write FSMs, handshakes decoded once here
// ==================================================
module axi_chan_fsm (
    input  logic clk,
    input  logic rst,
    // axi handshake inputs from the master
    input  logic arvalid,
    input  logic rready,
    input  logic awvalid,
    input  logic wvalid,
    input  logic bready,
    // axi handshake outputs
    output logic arready,
    output logic rvalid,
    output logic awready,
    output logic wready,
    output logic bvalid,
    // capture / commit strobes to the request buffer
    output logic load_raddr,
    output logic load_waddr,
    output logic load_wdata,
    output logic rd_fire,
    output logic wr_fire,
    // timer control
    output logic rd_start,
    output logic wr_start,
    input  logic rd_done,
    input  logic wr_done
);
    import sram_pkg::*;

    chan_state_t rd_state;
    chan_state_t rd_next;
    chan_state_t wr_state;
    chan_state_t wr_next;

    logic ar_hs;
    logic aw_hs;
    logic w_hs;

    // ==================================================
    // handshake decode
    // ==================================================
    // ready only in idle so one transaction per channel
    assign arready = (rd_state == st_idle);
    assign rvalid  = (rd_state == st_done);
    assign awready = (wr_state == st_idle);
    assign wready  = (wr_state == st_busy);
    assign bvalid  = (wr_state == st_done);

    assign ar_hs = arvalid & arready;
    assign aw_hs = awvalid & awready;
    assign w_hs  = wvalid & wready;

    // address capture and timer kick on the same edge
    assign load_raddr = ar_hs;
    assign rd_start   = ar_hs;
    assign load_waddr = aw_hs;
    assign load_wdata = w_hs;
    assign wr_start   = w_hs;

    // memory access lands when the timer expires
    assign rd_fire = (rd_state == st_access) & rd_done;
    assign wr_fire = (wr_state == st_access) & wr_done;

    // ==================================================
    // read channel
    // ==================================================
    always_comb begin
        rd_next = rd_state;
        case (rd_state)
            st_idle:   if (ar_hs) rd_next = st_access;
            st_access: if (rd_done) rd_next = st_done;
            st_done:   if (rready) rd_next = st_idle;
            default:   rd_next = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_state <= st_idle;
        end else begin
            rd_state <= rd_next;
        end
    end

    // ==================================================
    // write channel
    // ==================================================
    always_comb begin
        wr_next = wr_state;
        case (wr_state)
            st_idle:   if (aw_hs) wr_next = st_busy;
            // waiting on W
            st_busy:   if (w_hs) wr_next = st_access;
            st_access: if (wr_done) wr_next = st_done;
            st_done:   if (bready) wr_next = st_idle;
            default:   wr_next = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_state <= st_idle;
        end else begin
            wr_state <= wr_next;
        end
    end

    // response held under back-pressure
    a_rvalid_hold: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid);
    a_bvalid_hold: assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid);
    // read only starts from idle
    a_rd_start_idle: assert property (@(posedge clk) disable iff (rst)
        rd_start |-> rd_state == st_idle);

endmodule

// File: rtl/axi_lite_sram/access_timer.sv
// ==================================================
// access timer
// done pulse access_cycles cycles after a start pulse
// ==================================================
module access_timer #(
    parameter int access_cycles = 2
) (
    input  logic clk,
    input  logic rst,
    input  logic start,
    output logic done
);

    // 0 means idle
    logic [3:0] cnt;

    // stands in for the bank's latency, bank itself answers at once
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt  <= 4'd0;
            done <= 1'b0;
        end else begin
            // last count -> registered done pulse
            done <= (cnt == 4'd1);
            if (start && cnt == 4'd0) begin
                cnt <= 4'(access_cycles);
            end else if (cnt != 4'd0) begin
                cnt <= cnt - 4'd1;
            end
        end
    end

    // channel FSM never restarts a running timer
    a_no_restart: assert property (@(posedge clk) disable iff (rst)
        start |-> cnt == 4'd0);

endmodule

// File: rtl/axi_lite_sram/axi_req_buf.sv
// ==================================================
// request buffer
// captures address/data, decodes range, builds responses
// ==================================================
module axi_req_buf (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [sram_pkg::addr_w-1:0]    araddr,
    input  logic [sram_pkg::addr_w-1:0]    awaddr,
    input  logic [sram_pkg::data_w-1:0]    wdata,
    input  logic [sram_pkg::strb_w-1:0]    wstrb,
    // strobes from the channel FSM
    input  logic                           load_raddr,
    input  logic                           load_waddr,
    input  logic                           load_wdata,
    input  logic                           rd_fire,
    input  logic                           wr_fire,
    output logic [sram_pkg::data_w-1:0]    rdata,
    output sram_pkg::resp_t                rresp,
    output sram_pkg::resp_t                bresp,
    sram_port_if.req                       mem
);
    import sram_pkg::*;

    sram_addr_u        raddr_q;
    sram_addr_u        waddr_q;
    logic [data_w-1:0] wdata_q;
    logic [strb_w-1:0] wstrb_q;

    logic rd_ok;
    logic wr_ok;

    // ==================================================
    // capture
    // ==================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            raddr_q.raw <= addr_rst;
            waddr_q.raw <= addr_rst;
        end else begin
            if (load_raddr) raddr_q.raw <= araddr;
            if (load_waddr) waddr_q.raw <= awaddr;
        end
    end

    // payload only
    always_ff @(posedge clk) begin
        if (load_wdata) begin
            wdata_q <= wdata;
            wstrb_q <= wstrb;
        end
    end

    // ==================================================
    // decode
    // ==================================================
    // any tag bit set -> beyond the 1 KiB bank
    assign rd_ok = (raddr_q.fields.tag == '0);
    assign wr_ok = (waddr_q.fields.tag == '0);

    assign rresp = rd_ok ? resp_okay : resp_slverr;
    assign bresp = wr_ok ? resp_okay : resp_slverr;

    // bank port, out-of-range requests never reach it
    assign mem.rd_en    = rd_fire & rd_ok;
    assign mem.rd_index = raddr_q.fields.index;
    assign mem.wr_en    = wr_fire & wr_ok;
    assign mem.wr_index = waddr_q.fields.index;
    assign mem.wr_data  = wdata_q;
    assign mem.wr_strb  = wstrb_q;

    // error read returns zero
    assign rdata = rd_ok ? mem.rd_data : '0;

    a_no_bad_write: assert property (@(posedge clk) disable iff (rst)
        mem.wr_en |-> waddr_q.fields.tag == '0);

endmodule

// File: rtl/axi_lite_sram/sram_bank.sv
// ==================================================
// sram bank
// 256 words, registered read, byte-strobed write
// ==================================================
module sram_bank (
    input logic       clk,
    sram_port_if.bank mem
);
    import sram_pkg::*;

    localparam int depth = 2 ** index_w;

    logic [data_w-1:0] words [depth];

    // ==================================================
    // read port
    // ==================================================
    // holds its value between rd_en pulses
    always_ff @(posedge clk) begin
        if (mem.rd_en) begin
            mem.rd_data <= words[mem.rd_index];
        end
    end

    // ==================================================
    // write port
    // ==================================================
    // untouched lanes keep the stored byte
    always_ff @(posedge clk) begin
        if (mem.wr_en) begin
            for (int b = 0; b < strb_w; b++) begin
                if (mem.wr_strb[b]) begin
                    words[mem.wr_index][8*b +: 8] <= mem.wr_data[8*b +: 8];
                end
            end
        end
    end

endmodule

// File: rtl/axi_lite_sram/axi_lite_sram.sv
// ==================================================
// axi-lite sram slave
// channel FSMs, access timers, request buffer and bank
// ==================================================
module axi_lite_sram #(
    parameter int access_cycles = 2
) (
    input  logic                         clk,
    input  logic                         rst,
    // read address
    input  logic                         s_axi_arvalid,
    input  logic [sram_pkg::addr_w-1:0]  s_axi_araddr,
    output logic                         s_axi_arready,
    // read data
    input  logic                         s_axi_rready,
    output logic [sram_pkg::data_w-1:0]  s_axi_rdata,
    output logic                         s_axi_rvalid,
    output sram_pkg::resp_t              s_axi_rresp,
    // write address
    input  logic [sram_pkg::addr_w-1:0]  s_axi_awaddr,
    input  logic                         s_axi_awvalid,
    output logic                         s_axi_awready,
    // write data
    input  logic [sram_pkg::data_w-1:0]  s_axi_wdata,
    input  logic [sram_pkg::strb_w-1:0]  s_axi_wstrb,
    input  logic                         s_axi_wvalid,
    output logic                         s_axi_wready,
    // write response
    output sram_pkg::resp_t              s_axi_bresp,
    input  logic                         s_axi_bready,
    output logic                         s_axi_bvalid
);

    logic load_raddr;
    logic load_waddr;
    logic load_wdata;
    logic rd_fire;
    logic wr_fire;
    logic rd_start;
    logic wr_start;
    logic rd_done;
    logic wr_done;

    sram_port_if mem_if ();

    // ==================================================
    // control
    // ==================================================
    axi_chan_fsm u_fsm (
        .clk        (clk),
        .rst        (rst),
        .arvalid    (s_axi_arvalid),
        .rready     (s_axi_rready),
        .awvalid    (s_axi_awvalid),
        .wvalid     (s_axi_wvalid),
        .bready     (s_axi_bready),
        .arready    (s_axi_arready),
        .rvalid     (s_axi_rvalid),
        .awready    (s_axi_awready),
        .wready     (s_axi_wready),
        .bvalid     (s_axi_bvalid),
        .load_raddr (load_raddr),
        .load_waddr (load_waddr),
        .load_wdata (load_wdata),
        .rd_fire    (rd_fire),
        .wr_fire    (wr_fire),
        .rd_start   (rd_start),
        .wr_start   (wr_start),
        .rd_done    (rd_done),
        .wr_done    (wr_done)
    );

    // one timer per channel, channels run independently
    access_timer #(.access_cycles(access_cycles)) rd_timer (
        .clk   (clk),
        .rst   (rst),
        .start (rd_start),
        .done  (rd_done)
    );

    access_timer #(.access_cycles(access_cycles)) wr_timer (
        .clk   (clk),
        .rst   (rst),
        .start (wr_start),
        .done  (wr_done)
    );

    // ==================================================
    // datapath
    // ==================================================
    axi_req_buf u_buf (
        .clk        (clk),
        .rst        (rst),
        .araddr     (s_axi_araddr),
        .awaddr     (s_axi_awaddr),
        .wdata      (s_axi_wdata),
        .wstrb      (s_axi_wstrb),
        .load_raddr (load_raddr),
        .load_waddr (load_waddr),
        .load_wdata (load_wdata),
        .rd_fire    (rd_fire),
        .wr_fire    (wr_fire),
        .rdata      (s_axi_rdata),
        .rresp      (s_axi_rresp),
        .bresp      (s_axi_bresp),
        .mem        (mem_if.req)
    );

    sram_bank u_bank (
        .clk (clk),
        .mem (mem_if.bank)
    );

endmodule

// File: verification/tb_axi_lite_sram.sv
// ==================================================
// axi-lite sram testbench
// replays the golden list with random ready back-pressure
// ==================================================
module tb_axi_lite_sram;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int access_cycles  = 2;
    localparam int timeout_cycles = 50;
    localparam int max_lines      = 32;

    logic        clk;
    logic        rst;
    logic        s_axi_arvalid;
    logic [31:0] s_axi_araddr;
    logic        s_axi_arready;
    logic        s_axi_rready;
    logic [31:0] s_axi_rdata;
    logic        s_axi_rvalid;
    logic [1:0]  s_axi_rresp;
    logic [31:0] s_axi_awaddr;
    logic        s_axi_awvalid;
    logic        s_axi_awready;
    logic [31:0] s_axi_wdata;
    logic [3:0]  s_axi_wstrb;
    logic        s_axi_wvalid;
    logic        s_axi_wready;
    logic [1:0]  s_axi_bresp;
    logic        s_axi_bready;
    logic        s_axi_bvalid;

    // six words per golden line
    logic [31:0] golden [0:6*max_lines-1];
    int errors = 0;
    int n_ok   = 0;
    int n_bad  = 0;
    bit hung   = 1'b0;

    axi_lite_sram #(.access_cycles(access_cycles)) uut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ==================================================
    // checking helpers
    // ==================================================
    task automatic check_val(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
        if (act !== exp) begin
            $display("Fail at %0d ns: %s expected %h actual %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic report_hang(input string sig);
        $display("timeout: %s did not arrive within %0d cycles", sig, timeout_cycles);
        hung = 1'b1;
    endtask

    task automatic log_test(input string what, input int err_before);
        if (errors == err_before && !hung) begin
            n_ok++;
            $display("test %0d %s: ok", n_ok + n_bad, what);
        end else begin
            n_bad++;
            $display("test %0d %s: error", n_ok + n_bad, what);
        end
    endtask

    // ==================================================
    // read transaction
    // ==================================================
    task automatic read_word(input logic [31:0] addr, input logic [31:0] exp_data,
                             input logic [31:0] exp_resp);
        int n;
        int hold;
        logic [31:0] data0;
        logic [1:0]  resp0;
        @(posedge clk);
        s_axi_arvalid <= 1'b1;
        s_axi_araddr  <= addr;
        n = 0;
        @(negedge clk);
        while (!s_axi_arready) begin
            if (n == timeout_cycles) begin
                report_hang("s_axi_arready");
                return;
            end
            n++;
            @(negedge clk);
        end
        // AR handshake edge
        @(posedge clk);
        s_axi_arvalid <= 1'b0;
        n = 0;
        @(negedge clk);
        while (!s_axi_rvalid) begin
            if (n == timeout_cycles) begin
                report_hang("s_axi_rvalid");
                return;
            end
            @(posedge clk);
            n++;
            @(negedge clk);
        end
        // edges counted from the AR handshake
        check_val("rvalid latency", access_cycles + 1, n);
        data0 = s_axi_rdata;
        resp0 = s_axi_rresp;
        check_val("s_axi_arready", 0, s_axi_arready);
        // response must not move while rready is held off
        hold = $urandom % 6;
        repeat (hold) begin
            @(posedge clk);
            @(negedge clk);
            check_val("s_axi_rvalid", 1, s_axi_rvalid);
            check_val("s_axi_rdata", data0, s_axi_rdata);
            check_val("s_axi_rresp", resp0, s_axi_rresp);
            check_val("s_axi_arready", 0, s_axi_arready);
        end
        @(posedge clk);
        s_axi_rready <= 1'b1;
        // R handshake on this edge
        @(posedge clk);
        s_axi_rready <= 1'b0;
        check_val("s_axi_rdata", exp_data, data0);
        check_val("s_axi_rresp", exp_resp, resp0);
    endtask

    // ==================================================
    // write transaction (AW then W)
    // ==================================================
    task automatic write_word(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] strb, input logic [31:0] exp_resp);
        int n;
        int hold;
        logic [1:0] resp0;
        @(posedge clk);
        s_axi_awvalid <= 1'b1;
        s_axi_awaddr  <= addr;
        n = 0;
        @(negedge clk);
        while (!s_axi_awready) begin
            if (n == timeout_cycles) begin
                report_hang("s_axi_awready");
                return;
            end
            n++;
            @(negedge clk);
        end
        // data goes up on the AW handshake edge
        @(posedge clk);
        s_axi_awvalid <= 1'b0;
        s_axi_wvalid  <= 1'b1;
        s_axi_wdata   <= data;
        s_axi_wstrb   <= strb;
        n = 0;
        @(negedge clk);
        while (!s_axi_wready) begin
            if (n == timeout_cycles) begin
                report_hang("s_axi_wready");
                return;
            end
            n++;
            @(negedge clk);
        end
        // W handshake edge
        @(posedge clk);
        s_axi_wvalid <= 1'b0;
        n = 0;
        @(negedge clk);
        while (!s_axi_bvalid) begin
            if (n == timeout_cycles) begin
                report_hang("s_axi_bvalid");
                return;
            end
            @(posedge clk);
            n++;
            @(negedge clk);
        end
        check_val("bvalid latency", access_cycles + 1, n);
        resp0 = s_axi_bresp;
        hold = $urandom % 6;
        repeat (hold) begin
            @(posedge clk);
            @(negedge clk);
            check_val("s_axi_bvalid", 1, s_axi_bvalid);
            check_val("s_axi_bresp", resp0, s_axi_bresp);
        end
        @(posedge clk);
        s_axi_bready <= 1'b1;
        @(posedge clk);
        s_axi_bready <= 1'b0;
        check_val("s_axi_bresp", exp_resp, resp0);
    endtask

    // ==================================================
    // main sequence
    // ==================================================
    initial begin
        int i;
        int err0;
        logic [31:0] op;
        void'($urandom(78323));
        rst           <= 1'b1;
        s_axi_arvalid <= 1'b0;
        s_axi_araddr  <= '0;
        s_axi_rready  <= 1'b0;
        s_axi_awvalid <= 1'b0;
        s_axi_awaddr  <= '0;
        s_axi_wvalid  <= 1'b0;
        s_axi_wdata   <= '0;
        s_axi_wstrb   <= '0;
        s_axi_bready  <= 1'b0;
        $readmemh("verification/sram_golden.txt", golden);
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        // idle outputs right after reset
        @(negedge clk);
        err0 = errors;
        check_val("s_axi_arready", 1, s_axi_arready);
        check_val("s_axi_awready", 1, s_axi_awready);
        check_val("s_axi_rvalid", 0, s_axi_rvalid);
        check_val("s_axi_wready", 0, s_axi_wready);
        check_val("s_axi_bvalid", 0, s_axi_bvalid);
        log_test("reset state", err0);
        i = 0;
        while (!hung && i < max_lines && (golden[6*i] === 32'd0 ||
               golden[6*i] === 32'd1 || golden[6*i] === 32'd2)) begin
            op   = golden[6*i];
            err0 = errors;
            if (op == 32'd0) begin
                write_word(golden[6*i+1], golden[6*i+2], golden[6*i+3][3:0], golden[6*i+5]);
                log_test($sformatf("write %h", golden[6*i+1]), err0);
                i++;
            end else if (op == 32'd1) begin
                read_word(golden[6*i+1], golden[6*i+4], golden[6*i+5]);
                log_test($sformatf("read %h", golden[6*i+1]), err0);
                i++;
            end else begin
                // write on this line and read on the next run together
                fork
                    write_word(golden[6*i+1], golden[6*i+2], golden[6*i+3][3:0],
                               golden[6*i+5]);
                    read_word(golden[6*i+7], golden[6*i+10], golden[6*i+11]);
                join
                log_test($sformatf("write %h with read %h", golden[6*i+1],
                                   golden[6*i+7]), err0);
                i += 2;
            end
        end
        if (!hung && golden[6*i] !== 32'hf) begin
            $display("golden list is missing or does not end with the end marker");
            errors++;
        end
        $display("tests: %0d ok, %0d with errors", n_ok, n_bad);
        if (errors == 0 && !hung) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: verification/sram_golden.txt
// columns: op addr data strb exp_data exp_resp (hex)
// op 0 write, 1 read, 2 write alongside the next line's read, f end of list
0 00000000 11223344 f 00000000 0
1 00000000 00000000 0 11223344 0
0 00000010 a5a5a5a5 f 00000000 0
1 00000010 00000000 0 a5a5a5a5 0
// partial strobes merge into the stored word
0 00000010 000000ff 1 00000000 0
1 00000010 00000000 0 a5a5a5ff 0
0 00000010 12345600 6 00000000 0
1 00000010 00000000 0 a53456ff 0
0 00000010 cc000000 8 00000000 0
1 00000013 00000000 0 cc3456ff 0
// top word, then addresses past the bank
0 000003fc deadbeef f 00000000 0
1 000003fc 00000000 0 deadbeef 0
0 00000403 0badf00d f 00000000 2
1 00000403 00000000 0 00000000 2
1 00000000 00000000 0 11223344 0
0 80000020 55555555 f 00000000 2
// a read and a write in flight together
2 00000020 cafef00d f 00000000 0
1 00000010 00000000 0 cc3456ff 0
2 00000030 0000abcd f 00000000 0
1 000003fc 00000000 0 deadbeef 0
1 00000020 00000000 0 cafef00d 0
1 00000030 00000000 0 0000abcd 0
f 00000000 00000000 0 00000000 0

// File: project.f
common/sram_pkg.sv
common/sram_port_if.sv
rtl/axi_lite_sram/axi_chan_fsm.sv
rtl/axi_lite_sram/access_timer.sv
rtl/axi_lite_sram/axi_req_buf.sv
rtl/axi_lite_sram/sram_bank.sv
rtl/axi_lite_sram/axi_lite_sram.sv
verification/tb_axi_lite_sram.sv
